// ==== tb.f ====
source/frame_filter_pkg.sv
source/frame_check.sv
source/rx_ctrl.sv
source/axis_frame_fifo.sv
source/frame_stats.sv
source/frame_filter_top.sv
dv/frame_filter_props.sv
dv/frame_filter_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := frame_filter_tb
FILELIST := tb.f
FLAGS    := --binary --timing --assert
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
	  echo "FAIL: run ended without a result"; exit 1; \
	fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/frame_filter_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_filter_tb;

  localparam int DATA_WIDTH    = 8;
  localparam int MAX_LEN       = 12;
  localparam int DEPTH         = 16;
  localparam int SW            = frame_filter_pkg::STAT_WIDTH;
  localparam int KIND_GOOD     = 0;
  localparam int KIND_BAD_SUM  = 1;
  localparam int KIND_TOO_LONG = 2;

  logic                  clk;
  logic                  rst;
  logic [DATA_WIDTH-1:0] s_tdata;
  logic                  s_tvalid;
  logic                  s_tready;
  logic                  s_tlast;
  logic [DATA_WIDTH-1:0] m_tdata;
  logic                  m_tvalid;
  logic                  m_tready;
  logic                  m_tlast;
  logic [SW-1:0]         good_count;
  logic [SW-1:0]         bad_count;
  logic [SW-1:0]         drop_count;

  // expected output beats, each one the last flag above the data byte.
  logic [DATA_WIDTH:0]   exp_q [$];
  logic [7:0]            frame_buf [16];
  logic [31:0]           data_seed;
  logic [31:0]           stall_seed;
  int                    ready_mode;
  int                    beats_sent;
  int                    cycle_count;
  int                    good_model;
  int                    bad_model;
  int                    drop_model;
  int                    fail_count;

  frame_filter_top #(
    .DATA_WIDTH    (DATA_WIDTH),
    .ADDR_WIDTH    (4),
    .MAX_LEN       (MAX_LEN),
    .DROP_WHEN_FULL(1'b1)
  ) frame_filter_top_inst (
    .clk       (clk),
    .rst       (rst),
    .s_tdata   (s_tdata),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .s_tlast   (s_tlast),
    .m_tdata   (m_tdata),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tlast   (m_tlast),
    .good_count(good_count),
    .bad_count (bad_count),
    .drop_count(drop_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int pick(input int span);
    data_seed = lcg_next(data_seed);
    return int'(data_seed[30:16]) % span;
  endfunction

  function automatic logic [7:0] next_byte();
    data_seed = lcg_next(data_seed);
    return data_seed[23:16];
  endfunction

  task automatic report_failure(input string line);
    fail_count++;
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_counters();
    assert ({good_count, bad_count, drop_count} ==
            {SW'(good_model), SW'(bad_model), SW'(drop_model)})
      else report_failure($sformatf(
        "CHECK FAILED good_count,bad_count,drop_count got 0x%0h expected 0x%0h",
        {good_count, bad_count, drop_count},
        {SW'(good_model), SW'(bad_model), SW'(drop_model)}));
  endtask

  // starts and ends on a falling edge. With gate set it waits until the
  // frame surely fits, so no frame is lost to overflow.
  task automatic send_frame(input int kind, input int len, input bit gate);
    int         written;
    int         held;
    bit         fits;
    logic [7:0] sum;
    sum = 8'h00;
    for (int i = 0; i < len - 1; i++) begin
      frame_buf[i] = next_byte();
      sum ^= frame_buf[i];
    end
    // the closing byte zeroes the XOR of a good frame.
    frame_buf[len-1] = (kind == KIND_BAD_SUM) ? (sum ^ (8'h01 + 8'(pick(255)))) : sum;
    written = (len > MAX_LEN) ? MAX_LEN : len;
    while (gate && (exp_q.size() + written > DEPTH)) begin
      @(negedge clk);
    end
    // the head beat waits in the output register and no longer takes a buffer entry.
    held = exp_q.size() - ((exp_q.size() != 0) ? 1 : 0);
    fits = (held + written <= DEPTH);
    if (kind == KIND_GOOD) begin
      good_model++;
      if (fits) begin
        for (int i = 0; i < len; i++) begin
          exp_q.push_back({(i == len - 1) ? 1'b1 : 1'b0, frame_buf[i]});
        end
      end else begin
        drop_model++;
      end
    end else begin
      bad_model++;
    end
    for (int i = 0; i < len; i++) begin
      s_tvalid = 1'b1;
      s_tdata  = frame_buf[i];
      s_tlast  = (i == len - 1);
      // with drop-when-full the input never pushes back.
      assert (s_tready === 1'b1)
        else report_failure($sformatf("CHECK FAILED s_tready got 0x%0h expected 0x1",
                                      s_tready));
      @(negedge clk);
      beats_sent++;
    end
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    repeat (2) @(negedge clk);
    check_counters();
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // mode 0 keeps the output ready, mode 1 stalls it, mode 2 stalls at random.
  initial begin
    m_tready = 1'b1;
    forever begin
      @(negedge clk);
      if (ready_mode == 2) begin
        stall_seed = lcg_next(stall_seed);
        m_tready   = (stall_seed[31:30] != 2'b00);
      end else begin
        m_tready = (ready_mode == 0);
      end
    end
  end

  always @(posedge clk) begin
    logic [DATA_WIDTH:0] expected;
    if (!rst && m_tvalid && m_tready) begin
      if (exp_q.size() == 0) begin
        report_failure("an output beat arrived while no frame was expected");
      end else begin
        expected = exp_q.pop_front();
        assert ({m_tlast, m_tdata} == expected)
          else report_failure($sformatf("CHECK FAILED m_tlast,m_tdata got 0x%0h expected 0x%0h",
                                        {m_tlast, m_tdata}, expected));
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count <= 40 * beats_sent + 2000) begin
      @(posedge clk);
      cycle_count++;
    end
    report_failure("the watchdog expired before the tests finished");
  end

  initial begin
    int kind;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    s_tlast    = 1'b0;
    rst        = 1'b1;
    ready_mode = 0;
    beats_sent = 0;
    good_model = 0;
    bad_model  = 0;
    drop_model = 0;
    fail_count = 0;
    data_seed  = 32'h7f93_dbee;
    stall_seed = ~data_seed;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    send_frame(KIND_GOOD, 4, 1'b1);
    send_frame(KIND_GOOD, 12, 1'b1);
    send_frame(KIND_GOOD, 1, 1'b1);
    send_frame(KIND_BAD_SUM, 7, 1'b1);
    send_frame(KIND_GOOD, 6, 1'b1);
    send_frame(KIND_TOO_LONG, 15, 1'b1);
    send_frame(KIND_GOOD, 9, 1'b1);
    wait_drained();

    // with the output stalled only three frames of five beats fit.
    ready_mode = 1;
    @(negedge clk);
    for (int i = 0; i < 5; i++) begin
      send_frame(KIND_GOOD, 5, 1'b0);
    end
    ready_mode = 0;
    wait_drained();

    ready_mode = 2;
    for (int i = 0; i < 60; i++) begin
      kind = pick(10);
      if (kind < 6) begin
        send_frame(KIND_GOOD, pick(MAX_LEN) + 1, 1'b1);
      end else if (kind < 8) begin
        send_frame(KIND_BAD_SUM, pick(MAX_LEN) + 1, 1'b1);
      end else begin
        send_frame(KIND_TOO_LONG, MAX_LEN + 1 + pick(4), 1'b1);
      end
    end
    ready_mode = 0;
    wait_drained();
    check_counters();

    if (fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/frame_filter_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_filter_props #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input logic                        clk,
  input logic                        rst,
  input logic                        m_tvalid,
  input logic                        m_tready,
  input logic [DATA_WIDTH-1:0]       m_tdata,
  input logic                        m_tlast,
  input frame_filter_pkg::rx_state_t state,
  input logic [ADDR_WIDTH:0]         wr_ptr_cur
);

  // a stalled output beat holds still until it is taken.
  stall_stable: assert property (@(posedge clk) disable iff (rst)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
    else $error("output beat changed while stalled");

  reset_idle: assert property (@(posedge clk) rst |=> !m_tvalid)
    else $error("m_tvalid high right after reset");

  // the tail of an oversize frame never reaches the FIFO.
  no_write_in_discard: assert property (@(posedge clk) disable iff (rst)
    state == frame_filter_pkg::RX_DISCARD |=> $stable(wr_ptr_cur))
    else $error("FIFO write while discarding");

endmodule

bind frame_filter_top frame_filter_props #(
  .DATA_WIDTH(DATA_WIDTH),
  .ADDR_WIDTH(ADDR_WIDTH)
) props_inst (
  .clk        (clk),
  .rst        (rst),
  .m_tvalid   (m_tvalid),
  .m_tready   (m_tready),
  .m_tdata    (m_tdata),
  .m_tlast    (m_tlast),
  .state      (rx_ctrl_inst.state),
  .wr_ptr_cur (fifo_inst.wr_ptr_cur)
);

`default_nettype wire

// ==== source/frame_filter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_filter_top #(
  parameter int DATA_WIDTH     = 8,
  parameter int ADDR_WIDTH     = 4,
  parameter int MAX_LEN        = 12,
  parameter bit DROP_WHEN_FULL = 1'b1
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [DATA_WIDTH-1:0]                   s_tdata,
  input  logic                                    s_tvalid,
  output logic                                    s_tready,
  input  logic                                    s_tlast,
  output logic [DATA_WIDTH-1:0]                   m_tdata,
  output logic                                    m_tvalid,
  input  logic                                    m_tready,
  output logic                                    m_tlast,
  output logic [frame_filter_pkg::STAT_WIDTH-1:0] good_count,
  output logic [frame_filter_pkg::STAT_WIDTH-1:0] bad_count,
  output logic [frame_filter_pkg::STAT_WIDTH-1:0] drop_count
);

  logic [DATA_WIDTH-1:0]      fifo_tdata;
  logic                       fifo_tvalid;
  logic                       fifo_tready;
  logic                       fifo_tlast;
  logic                       fifo_tuser;
  logic                       beat_accept;
  logic                       beat_last;
  logic [DATA_WIDTH-1:0]      beat_data;
  logic                       sum_ok;
  logic                       len_over;
  logic                       verdict_valid;
  frame_filter_pkg::verdict_t verdict;
  logic                       overflow_drop;

  frame_check #(
    .DATA_WIDTH(DATA_WIDTH),
    .MAX_LEN   (MAX_LEN)
  ) frame_check_inst (
    .clk        (clk),
    .rst        (rst),
    .beat_accept(beat_accept),
    .beat_last  (beat_last),
    .beat_data  (beat_data),
    .sum_ok     (sum_ok),
    .len_over   (len_over)
  );

  rx_ctrl #(
    .DATA_WIDTH(DATA_WIDTH)
  ) rx_ctrl_inst (
    .clk          (clk),
    .rst          (rst),
    .s_tdata      (s_tdata),
    .s_tvalid     (s_tvalid),
    .s_tready     (s_tready),
    .s_tlast      (s_tlast),
    .fifo_tdata   (fifo_tdata),
    .fifo_tvalid  (fifo_tvalid),
    .fifo_tready  (fifo_tready),
    .fifo_tlast   (fifo_tlast),
    .fifo_tuser   (fifo_tuser),
    .beat_accept  (beat_accept),
    .beat_last    (beat_last),
    .beat_data    (beat_data),
    .sum_ok       (sum_ok),
    .len_over     (len_over),
    .verdict_valid(verdict_valid),
    .verdict      (verdict)
  );

  axis_frame_fifo #(
    .DATA_WIDTH    (DATA_WIDTH),
    .ADDR_WIDTH    (ADDR_WIDTH),
    .DROP_WHEN_FULL(DROP_WHEN_FULL)
  ) fifo_inst (
    .clk          (clk),
    .rst          (rst),
    .in_tdata     (fifo_tdata),
    .in_tvalid    (fifo_tvalid),
    .in_tready    (fifo_tready),
    .in_tlast     (fifo_tlast),
    .in_tuser     (fifo_tuser),
    .out_tdata    (m_tdata),
    .out_tvalid   (m_tvalid),
    .out_tready   (m_tready),
    .out_tlast    (m_tlast),
    .overflow_drop(overflow_drop)
  );

  frame_stats stats_inst (
    .clk          (clk),
    .rst          (rst),
    .verdict_valid(verdict_valid),
    .verdict      (verdict),
    .overflow_drop(overflow_drop),
    .good_count   (good_count),
    .bad_count    (bad_count),
    .drop_count   (drop_count)
  );

endmodule

`default_nettype wire

// ==== source/frame_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_stats (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       verdict_valid,
  input  frame_filter_pkg::verdict_t                 verdict,
  input  logic                                       overflow_drop,
  output logic [frame_filter_pkg::STAT_WIDTH-1:0]    good_count,
  output logic [frame_filter_pkg::STAT_WIDTH-1:0]    bad_count,
  output logic [frame_filter_pkg::STAT_WIDTH-1:0]    drop_count
);

  // counters stick at their maximum rather than wrap.
  function automatic logic [frame_filter_pkg::STAT_WIDTH-1:0] sat_inc(
    input logic [frame_filter_pkg::STAT_WIDTH-1:0] value
  );
    return (&value) ? value : value + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      good_count <= '0;
      bad_count  <= '0;
      drop_count <= '0;
    end else begin
      if (verdict_valid) begin
        if (verdict == frame_filter_pkg::VERDICT_GOOD) begin
          good_count <= sat_inc(good_count);
        end else begin
          bad_count <= sat_inc(bad_count);
        end
      end
      // a good frame lost to overflow shows in both good and drop counts.
      if (overflow_drop) begin
        drop_count <= sat_inc(drop_count);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/axis_frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_frame_fifo #(
  parameter int DATA_WIDTH     = 8,
  parameter int ADDR_WIDTH     = 4,
  parameter bit DROP_WHEN_FULL = 1'b1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [DATA_WIDTH-1:0] in_tdata,
  input  logic                  in_tvalid,
  output logic                  in_tready,
  input  logic                  in_tlast,
  input  logic                  in_tuser,
  output logic [DATA_WIDTH-1:0] out_tdata,
  output logic                  out_tvalid,
  input  logic                  out_tready,
  output logic                  out_tlast,
  output logic                  overflow_drop
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // each entry holds the last flag above the data byte.
  logic [DATA_WIDTH:0]   mem [DEPTH];
  logic [DATA_WIDTH:0]   out_reg;
  logic [ADDR_WIDTH:0]   wr_ptr_commit;
  logic [ADDR_WIDTH:0]   wr_ptr_cur;
  logic [ADDR_WIDTH:0]   rd_ptr;
  logic                  dropping;
  logic                  full_cur;
  logic                  empty;
  logic                  write;
  logic                  mem_we;
  logic                  read;

  // full means the frame in progress has caught up with the read side.
  assign full_cur = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                    (wr_ptr_cur[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

  // only committed frames are visible to the read side.
  assign empty = (wr_ptr_commit == rd_ptr);

  assign in_tready = DROP_WHEN_FULL ? 1'b1 : !full_cur;
  assign write     = in_tvalid && in_tready;
  assign mem_we    = write && !full_cur && !dropping;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= {in_tlast, in_tdata};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_commit <= '0;
      wr_ptr_cur    <= '0;
      dropping      <= 1'b0;
      overflow_drop <= 1'b0;
    end else begin
      overflow_drop <= 1'b0;
      if (write) begin
        if (full_cur || dropping) begin
          // no room, so the rest of this frame is thrown away.
          if (in_tlast) begin
            wr_ptr_cur    <= wr_ptr_commit;
            dropping      <= 1'b0;
            overflow_drop <= !in_tuser;
          end else begin
            dropping <= 1'b1;
          end
        end else if (in_tlast) begin
          if (in_tuser) begin
            wr_ptr_cur <= wr_ptr_commit;
          end else begin
            wr_ptr_cur    <= wr_ptr_cur + 1'b1;
            wr_ptr_commit <= wr_ptr_cur + 1'b1;
          end
        end else begin
          wr_ptr_cur <= wr_ptr_cur + 1'b1;
        end
      end
    end
  end

  // the output register loads when it is empty or its beat leaves.
  assign read = !empty && (!out_tvalid || out_tready);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr     <= '0;
      out_tvalid <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (!out_tvalid || out_tready) begin
        out_tvalid <= !empty;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      out_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

  assign out_tlast = out_reg[DATA_WIDTH];
  assign out_tdata = out_reg[DATA_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== source/rx_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_ctrl #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [DATA_WIDTH-1:0]       s_tdata,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  input  logic                        s_tlast,
  output logic [DATA_WIDTH-1:0]       fifo_tdata,
  output logic                        fifo_tvalid,
  input  logic                        fifo_tready,
  output logic                        fifo_tlast,
  output logic                        fifo_tuser,
  output logic                        beat_accept,
  output logic                        beat_last,
  output logic [DATA_WIDTH-1:0]       beat_data,
  input  logic                        sum_ok,
  input  logic                        len_over,
  output logic                        verdict_valid,
  output frame_filter_pkg::verdict_t  verdict
);

  frame_filter_pkg::rx_state_t state;
  frame_filter_pkg::rx_state_t state_next;
  logic                        discard;
  logic                        frame_close;

  assign discard = (state == frame_filter_pkg::RX_DISCARD);

  // beats go straight to the FIFO unless the tail of a long frame is being dropped.
  assign fifo_tdata  = s_tdata;
  assign fifo_tvalid = s_tvalid && !discard;
  assign s_tready    = discard ? 1'b1 : fifo_tready;

  assign beat_accept = fifo_tvalid && fifo_tready;
  assign beat_last   = s_tlast;
  assign beat_data   = s_tdata;

  // an oversize frame is closed early and marked so the FIFO rewinds it.
  assign fifo_tlast  = s_tlast || len_over;
  assign fifo_tuser  = len_over || !sum_ok;
  assign frame_close = beat_accept && fifo_tlast;

  always_comb begin
    state_next = state;
    case (state)
      frame_filter_pkg::RX_IDLE,
      frame_filter_pkg::RX_ACTIVE: begin
        if (beat_accept) begin
          if (len_over) begin
            state_next = frame_filter_pkg::RX_DISCARD;
          end else if (s_tlast) begin
            state_next = frame_filter_pkg::RX_IDLE;
          end else begin
            state_next = frame_filter_pkg::RX_ACTIVE;
          end
        end
      end
      frame_filter_pkg::RX_DISCARD: begin
        if (s_tvalid && s_tlast) begin
          state_next = frame_filter_pkg::RX_IDLE;
        end
      end
      default: state_next = frame_filter_pkg::RX_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= frame_filter_pkg::RX_IDLE;
      verdict_valid <= 1'b0;
    end else begin
      state         <= state_next;
      verdict_valid <= frame_close;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_close) begin
      if (len_over) begin
        verdict <= frame_filter_pkg::VERDICT_TOO_LONG;
      end else if (sum_ok) begin
        verdict <= frame_filter_pkg::VERDICT_GOOD;
      end else begin
        verdict <= frame_filter_pkg::VERDICT_BAD_SUM;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/frame_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_check #(
  parameter int DATA_WIDTH = 8,
  parameter int MAX_LEN    = 12
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  beat_accept,
  input  logic                  beat_last,
  input  logic [DATA_WIDTH-1:0] beat_data,
  output logic                  sum_ok,
  output logic                  len_over
);

  localparam int CNT_WIDTH = $clog2(MAX_LEN + 1);

  logic [DATA_WIDTH-1:0] xor_q;
  logic [CNT_WIDTH-1:0]  count_q;
  logic [DATA_WIDTH-1:0] xor_next;
  logic                  frame_end;

  // the checksum byte makes the XOR of the whole frame zero.
  assign xor_next = xor_q ^ beat_data;
  assign sum_ok   = (xor_next == '0);

  // count_q holds the beats already taken, so this beat is number count_q + 1.
  assign len_over = beat_accept && !beat_last &&
                    (count_q == CNT_WIDTH'(MAX_LEN - 1));

  // a frame ends on its last beat or when it is cut short for length.
  assign frame_end = beat_accept && (beat_last || len_over);

  always_ff @(posedge clk) begin
    if (rst) begin
      xor_q   <= '0;
      count_q <= '0;
    end else if (frame_end) begin
      xor_q   <= '0;
      count_q <= '0;
    end else if (beat_accept) begin
      xor_q   <= xor_next;
      count_q <= count_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/frame_filter_pkg.sv ====
`default_nettype none

package frame_filter_pkg;

  // receive side of the filter. RX_DISCARD swallows the tail of an oversize frame.
  typedef enum logic [1:0] {
    RX_IDLE    = 2'd0,
    RX_ACTIVE  = 2'd1,
    RX_DISCARD = 2'd2
  } rx_state_t;

  // outcome of one frame, issued once per frame when it closes.
  typedef enum logic [1:0] {
    VERDICT_GOOD     = 2'd0,
    VERDICT_BAD_SUM  = 2'd1,
    VERDICT_TOO_LONG = 2'd2
  } verdict_t;

  // width of each statistics counter.
  localparam int STAT_WIDTH = 16;

endpackage

`default_nettype wire
